/* src/dequant_types_pkg.sv */
// Datapath types assume 16-bit two's complement operands and a 32-bit product; outputs saturate to 16 bits
package dequant_types_pkg;

    // Quantized activation or weight value
    typedef logic signed [15:0] qval_t;

    // Fixed-point scale, fraction width is set per design by FRAC_BITS
    typedef logic signed [15:0] scale_t;

    // Dequantized result after shift and clamp
    typedef logic signed [15:0] deq_t;

    // Full-width product of qval_t and scale_t, wide enough for every operand pair
    typedef logic signed [31:0] product_t;

    // Clamp limits of the output
    localparam deq_t DEQ_MAX = 16'sh7fff;
    localparam deq_t DEQ_MIN = 16'sh8000;

endpackage

/* src/dequant_ctrl_pkg.sv */
// Control types for the lane array; pointers are 4 bits wide, so at most 16 lanes are supported
package dequant_ctrl_pkg;

    // Largest lane count a lane_idx_t pointer can address
    localparam int MAX_LANES = 16;

    // Round-robin pointer into the lane array
    typedef logic [3:0] lane_idx_t;

    // Per-lane FSM
    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_MUL  = 2'd1,
        LANE_HOLD = 2'd2
    } lane_state_e;

endpackage

/* src/split_mult_16x16.sv */
// Purely combinational signed 16x16 multiply, exact for all inputs, no pipeline stage inside
`timescale 1ns/1ns

module split_mult_16x16
    import dequant_types_pkg::*;
(
    input  qval_t    a,
    input  scale_t   b,
    output product_t product
);

    // High bytes carry the sign, low bytes are plain magnitudes
    logic signed [7:0]  a_hi;
    logic signed [7:0]  b_hi;
    logic        [7:0]  a_lo;
    logic        [7:0]  b_lo;

    logic signed [15:0] pp_hh;
    logic signed [16:0] pp_hl;
    logic signed [16:0] pp_lh;
    logic        [15:0] pp_ll;
    logic signed [17:0] mid_sum;

    product_t hh_ext;
    product_t mid_ext;
    product_t ll_ext;

    assign a_hi = a[15:8];
    assign b_hi = b[15:8];
    assign a_lo = a[7:0];
    assign b_lo = b[7:0];

    // Cross terms mix a signed byte with a zero-extended unsigned byte
    assign pp_hh = a_hi * b_hi;
    assign pp_hl = a_hi * $signed({1'b0, b_lo});
    assign pp_lh = $signed({1'b0, a_lo}) * b_hi;
    assign pp_ll = a_lo * b_lo;

    assign mid_sum = pp_hl + pp_lh;

    // Align the partial products to their byte weights
    assign hh_ext  = {pp_hh, 16'd0};
    assign mid_ext = {{6{mid_sum[17]}}, mid_sum, 8'd0};
    assign ll_ext  = {16'd0, pp_ll};

    assign product = hh_ext + mid_ext + ll_ext;

endmodule

/* src/dequant_lane.sv */
// One item in flight per lane, at least 3 cycles per item; shift floors toward -inf, FRAC_BITS 0..16
`timescale 1ns/1ns

module dequant_lane
    import dequant_types_pkg::*;
    import dequant_ctrl_pkg::*;
#(
    parameter int FRAC_BITS = 8
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  qval_t  qval,
    input  scale_t scale,
    output logic   out_valid,
    input  logic   out_ready,
    output deq_t   deq
);

    lane_state_e state_q;

    qval_t    qval_q;
    scale_t   scale_q;
    deq_t     result_q;

    product_t product;
    product_t shifted;
    deq_t     sat_result;

    // Handshakes come straight from the state
    assign in_ready  = (state_q == LANE_IDLE);
    assign out_valid = (state_q == LANE_HOLD);
    assign deq       = result_q;

    split_mult_16x16 i_split_mult_16x16 (
        .a       (qval_q),
        .b       (scale_q),
        .product (product)
    );

    // Arithmetic shift gives floor rounding for negative products
    assign shifted = product >>> FRAC_BITS;

    always_comb begin
        if (shifted > product_t'(DEQ_MAX)) begin
            sat_result = DEQ_MAX;
        end else if (shifted < product_t'(DEQ_MIN)) begin
            sat_result = DEQ_MIN;
        end else begin
            sat_result = deq_t'(shifted);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LANE_IDLE;
        end else begin
            case (state_q)
                LANE_IDLE: if (in_valid) state_q <= LANE_MUL;
                LANE_MUL:  state_q <= LANE_HOLD;
                LANE_HOLD: if (out_ready) state_q <= LANE_IDLE;
                default:   state_q <= LANE_IDLE;
            endcase
        end
    end

    // Operands load on acceptance, result loads one cycle later
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            qval_q  <= qval;
            scale_q <= scale;
        end
        if (state_q == LANE_MUL) begin
            result_q <= sat_result;
        end
    end

endmodule

/* src/lane_dispatcher.sv */
// Strict round-robin steering; stalls on a busy lane even if others are free, NUM_LANES 1..16
`timescale 1ns/1ns

module lane_dispatcher
    import dequant_types_pkg::*;
    import dequant_ctrl_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  qval_t                qval,
    input  scale_t               scale,
    output logic [NUM_LANES-1:0] lane_in_valid,
    input  logic [NUM_LANES-1:0] lane_in_ready,
    output qval_t                lane_qval,
    output scale_t               lane_scale
);

    lane_idx_t wr_ptr;

    // Pointer width limits the lane count
    if (NUM_LANES < 1 || NUM_LANES > MAX_LANES) begin : g_bad_lanes
        $error("lane_dispatcher: NUM_LANES must lie in 1..%0d", MAX_LANES);
    end

    // Operands go to every lane, only the selected one sees valid
    assign lane_qval  = qval;
    assign lane_scale = scale;

    always_comb begin
        in_ready = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (wr_ptr == lane_idx_t'(i)) begin
                lane_in_valid[i] = in_valid;
                in_ready         = lane_in_ready[i];
            end else begin
                lane_in_valid[i] = 1'b0;
            end
        end
    end

    // Advance on each accepted item, wrap at the last lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (in_valid && in_ready) begin
            if (wr_ptr == lane_idx_t'(NUM_LANES - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

/* src/lane_collector.sv */
// Drains lanes in the dispatcher's round-robin order, so output order equals input order
`timescale 1ns/1ns

module lane_collector
    import dequant_types_pkg::*;
    import dequant_ctrl_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_LANES-1:0] lane_out_valid,
    output logic [NUM_LANES-1:0] lane_out_ready,
    input  deq_t                 lane_deq [NUM_LANES],
    output logic                 out_valid,
    input  logic                 out_ready,
    output deq_t                 deq
);

    lane_idx_t rd_ptr;

    // Output mux and ready return for the lane under the read pointer
    always_comb begin
        out_valid = 1'b0;
        deq       = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (rd_ptr == lane_idx_t'(i)) begin
                out_valid         = lane_out_valid[i];
                deq               = lane_deq[i];
                lane_out_ready[i] = out_ready;
            end else begin
                lane_out_ready[i] = 1'b0;
            end
        end
    end

    // A later lane may finish first, it simply waits for its turn
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (out_valid && out_ready) begin
            if (rd_ptr == lane_idx_t'(NUM_LANES - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* src/dequant_array_top.sv */
// Dequantizer array with valid/ready streams; floor rounding only, single global scale format
`timescale 1ns/1ns

module dequant_array_top
    import dequant_types_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int FRAC_BITS = 8
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  qval_t  qval,
    input  scale_t scale,
    output logic   out_valid,
    input  logic   out_ready,
    output deq_t   deq
);

    logic [NUM_LANES-1:0] lane_in_valid;
    logic [NUM_LANES-1:0] lane_in_ready;
    qval_t                lane_qval;
    scale_t               lane_scale;

    logic [NUM_LANES-1:0] lane_out_valid;
    logic [NUM_LANES-1:0] lane_out_ready;
    deq_t                 lane_deq [NUM_LANES];

    lane_dispatcher #(
        .NUM_LANES (NUM_LANES)
    ) i_lane_dispatcher (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .qval          (qval),
        .scale         (scale),
        .lane_in_valid (lane_in_valid),
        .lane_in_ready (lane_in_ready),
        .lane_qval     (lane_qval),
        .lane_scale    (lane_scale)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        dequant_lane #(
            .FRAC_BITS (FRAC_BITS)
        ) i_dequant_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (lane_in_valid[i]),
            .in_ready  (lane_in_ready[i]),
            .qval      (lane_qval),
            .scale     (lane_scale),
            .out_valid (lane_out_valid[i]),
            .out_ready (lane_out_ready[i]),
            .deq       (lane_deq[i])
        );
    end

    lane_collector #(
        .NUM_LANES (NUM_LANES)
    ) i_lane_collector (
        .clk            (clk),
        .rst_n          (rst_n),
        .lane_out_valid (lane_out_valid),
        .lane_out_ready (lane_out_ready),
        .lane_deq       (lane_deq),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .deq            (deq)
    );

endmodule

/* bench/dequant_array_checker.sv */
// Bound into dequant_array_top; handshake rules hold only outside reset, except the reset check
`timescale 1ns/1ns

module dequant_array_checker
    import dequant_types_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic in_ready,
    input logic out_valid,
    input logic out_ready,
    input deq_t deq
);

    // Nothing offered while reset holds or on the first edge after release
    reset_out_valid_low: assert property (
        @(posedge clk) (!rst_n || $rose(rst_n)) |-> !out_valid
    ) else $error("out_valid high during or right after reset");

    // A stalled result keeps its valid and its value
    stalled_output_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(deq))
    ) else $error("output changed while stalled");

    in_ready_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(in_ready)
    ) else $error("in_ready unknown after reset");

endmodule

/* bench/dequant_array_tb.sv */
// Runs with the DUT's default parameters; FRAC_BITS and NUM_LANES are read from the DUT hierarchy
`timescale 1ns/1ns

module dequant_array_tb
    import dequant_types_pkg::*;
;

    localparam int unsigned SEED           = 32'hacdef37c;
    localparam int          PLANNED_ITEMS  = 8 + 6 + 7 + 200 + 300;
    localparam int unsigned TIMEOUT_CYCLES = 8 * PLANNED_ITEMS + 1000;
    localparam int          READY_LEN      = 1024;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   in_valid;
    logic   in_ready;
    qval_t  qval;
    scale_t scale;
    logic   out_valid;
    logic   out_ready;
    deq_t   deq;

    // Stimulus waiting to be sent and the idle cycles before each item
    qval_t  stim_qval[$];
    scale_t stim_scale[$];
    int     gap_q[$];

    // Pairs accepted by the DUT and not yet seen at the output
    qval_t  sent_qval[$];
    scale_t sent_scale[$];

    bit     ready_pattern [READY_LEN];
    bit     check_burst_ready;

    int          frac_bits;
    int          num_lanes;
    int          error_count  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int unsigned cycle_count  = 0;

    dequant_array_top i_dequant_array_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .qval      (qval),
        .scale     (scale),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .deq       (deq)
    );

    bind dequant_array_top dequant_array_checker i_dequant_array_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .deq       (deq)
    );

    always #5 clk = ~clk;

    // Stops a run that no longer makes progress
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            if (sent_qval.size() != 0) begin
                $display("Results were missing for %0d accepted items", sent_qval.size());
            end
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Expected output is the full product, floor shifted and clamped to signed 16 bits
    function automatic deq_t ref_dequant(input qval_t q, input scale_t s, input int shift);
        longint prod;
        longint shifted;
        prod    = longint'(q) * longint'(s);
        shifted = prod >>> shift;
        if (shifted > 64'sd32767) begin
            return 16'sh7fff;
        end else if (shifted < -64'sd32768) begin
            return 16'sh8000;
        end
        return deq_t'(shifted);
    endfunction

    task automatic check_value(input longint actual, input longint expected, input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0d, expected %0d",
                     $time, msg, actual, expected);
            error_count++;
        end
    endtask

    task automatic add_pair(input qval_t q, input scale_t s, input int gap);
        stim_qval.push_back(q);
        stim_scale.push_back(s);
        gap_q.push_back(gap);
    endtask

    task automatic add_random_pairs(input int n, input bit with_gaps);
        qval_t  q;
        scale_t s;
        int     gap;
        for (int i = 0; i < n; i++) begin
            q   = qval_t'($urandom);
            s   = scale_t'($urandom);
            gap = with_gaps ? int'($urandom_range(3, 0)) : 0;
            add_pair(q, s, gap);
        end
    endtask

    // Sink output ready per cycle is all high unless back-pressure is wanted
    task automatic fill_ready_pattern(input bit random_low);
        for (int i = 0; i < READY_LEN; i++) begin
            ready_pattern[i] = random_low ? ($urandom_range(1, 0) == 1) : 1'b1;
        end
    endtask

    // Source offers each item and holds it until the DUT takes it
    task automatic drive_items();
        bit accepted;
        bit first_try;
        int gap;
        int sent;
        sent = 0;
        while (stim_qval.size() > 0) begin
            gap = gap_q.pop_front();
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            in_valid  = 1'b1;
            qval      = stim_qval.pop_front();
            scale     = stim_scale.pop_front();
            first_try = 1'b1;
            accepted  = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = in_ready;
                if (check_burst_ready && first_try && sent > 0 && num_lanes >= 3) begin
                    check_value(longint'(in_ready), 64'sd1, "in_ready during burst");
                end
                first_try = 1'b0;
                if (accepted) begin
                    sent_qval.push_back(qval);
                    sent_scale.push_back(scale);
                end
                @(posedge clk);
                #1;
            end
            in_valid = 1'b0;
            sent++;
        end
    endtask

    // Sink takes results in order and compares them with the reference
    task automatic collect_results(input int count);
        int     received;
        int     step;
        qval_t  q;
        scale_t s;
        received = 0;
        step     = 0;
        while (received < count) begin
            out_ready = ready_pattern[step % READY_LEN];
            step++;
            @(negedge clk);
            if (out_valid && out_ready) begin
                if (sent_qval.size() == 0) begin
                    $display("Error at %0t ns: a result came out with no input pending", $time);
                    error_count++;
                end else begin
                    q = sent_qval.pop_front();
                    s = sent_scale.pop_front();
                    check_value(longint'(deq), longint'(ref_dequant(q, s, frac_bits)),
                                $sformatf("deq for qval %0d scale %0d", q, s));
                end
                received++;
            end
            @(posedge clk);
            #1;
        end
        out_ready = 1'b0;
    endtask

    task automatic run_test(input string name);
        int errors_before;
        int count;
        bit stray;
        errors_before = error_count;
        count         = stim_qval.size();
        stray         = 1'b0;
        fork
            drive_items();
            collect_results(count);
        join
        // A duplicated result would still be offered here
        repeat (4) begin
            @(negedge clk);
            if (out_valid && !stray) begin
                $display("Error at %0t ns: extra result offered after test %s", $time, name);
                error_count++;
                stray = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        if (error_count == errors_before) begin
            tests_passed++;
            $display("Test %s passed, %0d items", name, count);
        end else begin
            tests_failed++;
            $display("Test %s failed, %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        frac_bits = i_dequant_array_top.FRAC_BITS;
        num_lanes = i_dequant_array_top.NUM_LANES;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        qval      = '0;
        scale     = '0;
        out_ready = 1'b0;
        check_burst_ready = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        fill_ready_pattern(1'b0);
        add_pair(16'sd100, 16'sd256, 0);
        add_pair(-16'sd100, 16'sd256, 0);
        add_pair(16'sd1000, 16'sd128, 0);
        add_pair(-16'sd5, 16'sd512, 0);
        add_pair(16'sh7fff, 16'sd256, 0);
        add_pair(16'sh8000, 16'sd256, 0);
        add_pair(16'sd37, 16'sd300, 0);
        add_pair(16'sd12, -16'sd256, 0);
        run_test("in_range");

        add_pair(16'sh8000, 16'sh8000, 0);
        add_pair(16'sh8000, 16'sh7fff, 0);
        add_pair(16'sh7fff, 16'sh7fff, 0);
        add_pair(16'sd20000, 16'sd512, 0);
        add_pair(-16'sd20000, 16'sd512, 0);
        add_pair(16'sh7fff, 16'sh8000, 0);
        run_test("saturation");

        // Negative products with fraction bits left over
        add_pair(-16'sd1, 16'sd1, 0);
        add_pair(-16'sd1, 16'sd255, 0);
        add_pair(-16'sd3, 16'sd100, 0);
        add_pair(16'sd3, 16'sd100, 0);
        add_pair(16'sd0, 16'sd12345, 0);
        add_pair(16'sh8000, 16'sd0, 0);
        add_pair(-16'sd257, 16'sd1, 0);
        run_test("floor_and_zero");

        check_burst_ready = 1'b1;
        add_random_pairs(200, 1'b0);
        run_test("full_throughput");
        check_burst_ready = 1'b0;

        fill_ready_pattern(1'b1);
        add_random_pairs(300, 1'b1);
        run_test("back_pressure");

        if (sent_qval.size() != 0) begin
            $display("Error: %0d accepted items never produced a result", sent_qval.size());
            error_count++;
        end
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
src/dequant_types_pkg.sv
src/dequant_ctrl_pkg.sv
src/split_mult_16x16.sv
src/dequant_lane.sv
src/lane_dispatcher.sv
src/lane_collector.sv
src/dequant_array_top.sv
bench/dequant_array_checker.sv
bench/dequant_array_tb.sv

/* Makefile */
# Verilator flow for the dequantizer array testbench

VERILATOR  ?= verilator
TOP        ?= dequant_array_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
SOURCES    := $(wildcard src/*.sv bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
